/* Makefile */
# Verilator flow for the instruction cache

LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module icache_top \
		icache_pkg.sv cache_array.sv icache_ctrl.sv icache_refill.sv icache_top.sv

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_icache \
		-f sim.f -Mdir obj_dir
	./obj_dir/Vtb_icache | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* cache_array.sv */
`timescale 1ns/1ps

module cache_array #(
    parameter int  DEPTH_W = 4,
    parameter type entry_t = logic [31:0]
) (
    input  logic               clk,
    input  logic [DEPTH_W-1:0] rd_index,
    input  logic               wr_en,
    input  logic [DEPTH_W-1:0] wr_index,
    input  entry_t             wr_entry,
    output entry_t             rd_entry
);

    localparam int DEPTH = 1 << DEPTH_W;

    entry_t mem [DEPTH];

    // single write port
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_index] <= wr_entry;
        end
    end

    // registered read, entry shows up the cycle after the index
    always_ff @(posedge clk)
    begin
        rd_entry <= mem[rd_index];
    end

endmodule

/* icache_ctrl.sv */
`timescale 1ns/1ps

module icache_ctrl
    import icache_pkg::*;
#(
    parameter int INDEX_W = INDEX_W_DEF
) (
    input  logic               clk,
    input  logic               rst,

    input  logic               cpu_req_valid,
    input  addr_t              cpu_req_addr,
    output logic               cpu_req_ready,
    output logic               cpu_resp_valid,
    output word_t              cpu_resp_data,
    input  logic               flush,

    output logic [INDEX_W-1:0] arr_rd_index,
    output logic               arr_wr_en,
    output logic [INDEX_W-1:0] arr_wr_index,
    input  tag_entry_t         tag_rd_entry,
    output tag_entry_t         tag_wr_entry,
    input  word_t              data_rd_word,
    output word_t              data_wr_word,

    output logic               refill_start,
    output addr_t              refill_addr,
    input  logic               refill_done,
    input  word_t              refill_data
);

    localparam int TAG_W = ADDR_W - OFFSET_W - INDEX_W;

    ctrl_state_t        state;
    ctrl_state_t        state_nxt;
    logic [INDEX_W-1:0] flush_cnt;
    addr_t              req_addr;
    word_t              resp_data;
    logic               req_fire;
    logic               hit;
    logic [INDEX_W-1:0] req_index;
    logic [TAG_W-1:0]   req_tag;

    assign req_index = req_addr[OFFSET_W +: INDEX_W];
    assign req_tag   = req_addr[ADDR_W-1 -: TAG_W];

    // a pending flush blocks new requests
    assign cpu_req_ready = (state == IDLE) && !flush;
    assign req_fire      = cpu_req_valid && cpu_req_ready;

    assign hit = tag_rd_entry.valid && (tag_rd_entry.tag == req_tag);

    always_comb
    begin
        state_nxt = state;
        case (state)
            IDLE:
            begin
                if (flush)
                begin
                    state_nxt = FLUSH;
                end
                else if (cpu_req_valid)
                begin
                    state_nxt = LOOKUP;
                end
            end
            LOOKUP:  state_nxt = hit ? RESPOND : REFILL;
            REFILL:
            begin
                if (refill_done)
                begin
                    state_nxt = RESPOND;
                end
            end
            RESPOND: state_nxt = IDLE;
            FLUSH:
            begin
                if (flush_cnt == '1)
                begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    // start in FLUSH so all valid bits are cleared first
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= FLUSH;
            flush_cnt <= '0;
        end
        else
        begin
            state <= state_nxt;
            if (state == FLUSH)
            begin
                flush_cnt <= flush_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (req_fire)
        begin
            req_addr <= cpu_req_addr;
        end
        if (state == LOOKUP && hit)
        begin
            resp_data <= data_rd_word;
        end
        else if (state == REFILL && refill_done)
        begin
            resp_data <= refill_data;
        end
    end

    // read straight from the incoming address while idle
    assign arr_rd_index = (state == IDLE) ? cpu_req_addr[OFFSET_W +: INDEX_W] : req_index;

    always_comb
    begin
        arr_wr_en          = 1'b0;
        arr_wr_index       = req_index;
        tag_wr_entry.valid = 1'b1;
        tag_wr_entry.tag   = req_tag;
        if (state == FLUSH)
        begin
            arr_wr_en          = 1'b1;
            arr_wr_index       = flush_cnt;
            tag_wr_entry.valid = 1'b0;
            tag_wr_entry.tag   = '0;
        end
        else if (state == REFILL && refill_done)
        begin
            arr_wr_en = 1'b1;
        end
    end

    assign data_wr_word = refill_data;

    assign refill_start = (state == LOOKUP) && !hit;
    assign refill_addr  = {req_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

    assign cpu_resp_valid = (state == RESPOND);
    assign cpu_resp_data  = resp_data;

    // returned word only while a miss is waiting for it
    assert property (@(posedge clk) disable iff (rst)
        refill_done |-> state == REFILL);

    // flush arrives as a one-cycle strobe
    assert property (@(posedge clk) disable iff (rst)
        flush |=> !flush);

endmodule

/* icache_pkg.sv */
package icache_pkg;

    // address split: tag | index | word offset
    localparam int ADDR_W      = 32;
    localparam int WORD_W      = 32;
    localparam int OFFSET_W    = 2;

    // 16 lines unless the top level overrides it
    localparam int INDEX_W_DEF = 4;
    localparam int TAG_W_DEF   = ADDR_W - OFFSET_W - INDEX_W_DEF;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;

    // one entry of the tag store
    typedef struct packed {
        logic                 valid;
        logic [TAG_W_DEF-1:0] tag;
    } tag_entry_t;

    // controller states
    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        LOOKUP  = 3'd1,
        REFILL  = 3'd2,
        RESPOND = 3'd3,
        FLUSH   = 3'd4
    } ctrl_state_t;

endpackage

/* icache_refill.sv */
`timescale 1ns/1ps

module icache_refill
    import icache_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    input  logic  refill_start,
    input  addr_t refill_addr,
    output logic  refill_done,
    output word_t refill_data,

    output logic  mem_req_valid,
    output addr_t mem_req_addr,
    input  logic  mem_req_ready,
    input  word_t mem_rdata
);

    logic mem_fire;

    assign mem_fire = mem_req_valid && mem_req_ready;

    // request stays up through back-pressure
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mem_req_valid <= 1'b0;
            refill_done   <= 1'b0;
        end
        else
        begin
            refill_done <= mem_fire;
            if (refill_start)
            begin
                mem_req_valid <= 1'b1;
            end
            else if (mem_fire)
            begin
                mem_req_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (refill_start)
        begin
            mem_req_addr <= refill_addr;
        end
        // rdata is only valid on the accepting edge
        if (mem_fire)
        begin
            refill_data <= mem_rdata;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr));

    // one outstanding request only
    assert property (@(posedge clk) disable iff (rst)
        refill_start |-> !mem_req_valid && !refill_done);

endmodule

/* icache_top.sv */
`timescale 1ns/1ps

module icache_top
    import icache_pkg::*;
#(
    parameter int INDEX_W = INDEX_W_DEF
) (
    input  logic  clk,
    input  logic  rst,

    input  logic  cpu_req_valid,
    input  addr_t cpu_req_addr,
    output logic  cpu_req_ready,
    output logic  cpu_resp_valid,
    output word_t cpu_resp_data,

    input  logic  flush,

    output logic  mem_req_valid,
    output addr_t mem_req_addr,
    input  logic  mem_req_ready,
    input  word_t mem_rdata
);

    logic [INDEX_W-1:0] arr_rd_index;
    logic               arr_wr_en;
    logic [INDEX_W-1:0] arr_wr_index;
    tag_entry_t         tag_rd_entry;
    tag_entry_t         tag_wr_entry;
    word_t              data_rd_word;
    word_t              data_wr_word;
    logic               refill_start;
    addr_t              refill_addr;
    logic               refill_done;
    word_t              refill_data;

    icache_ctrl #(
        .INDEX_W (INDEX_W)
    ) ctrl_i (
        .clk            (clk),
        .rst            (rst),
        .cpu_req_valid  (cpu_req_valid),
        .cpu_req_addr   (cpu_req_addr),
        .cpu_req_ready  (cpu_req_ready),
        .cpu_resp_valid (cpu_resp_valid),
        .cpu_resp_data  (cpu_resp_data),
        .flush          (flush),
        .arr_rd_index   (arr_rd_index),
        .arr_wr_en      (arr_wr_en),
        .arr_wr_index   (arr_wr_index),
        .tag_rd_entry   (tag_rd_entry),
        .tag_wr_entry   (tag_wr_entry),
        .data_rd_word   (data_rd_word),
        .data_wr_word   (data_wr_word),
        .refill_start   (refill_start),
        .refill_addr    (refill_addr),
        .refill_done    (refill_done),
        .refill_data    (refill_data)
    );

    // valid bit and tag per line
    cache_array #(
        .DEPTH_W (INDEX_W),
        .entry_t (tag_entry_t)
    ) tag_array_i (
        .clk      (clk),
        .rd_index (arr_rd_index),
        .wr_en    (arr_wr_en),
        .wr_index (arr_wr_index),
        .wr_entry (tag_wr_entry),
        .rd_entry (tag_rd_entry)
    );

    // one instruction word per line
    cache_array #(
        .DEPTH_W (INDEX_W),
        .entry_t (word_t)
    ) data_array_i (
        .clk      (clk),
        .rd_index (arr_rd_index),
        .wr_en    (arr_wr_en),
        .wr_index (arr_wr_index),
        .wr_entry (data_wr_word),
        .rd_entry (data_rd_word)
    );

    icache_refill refill_i (
        .clk           (clk),
        .rst           (rst),
        .refill_start  (refill_start),
        .refill_addr   (refill_addr),
        .refill_done   (refill_done),
        .refill_data   (refill_data),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_ready (mem_req_ready),
        .mem_rdata     (mem_rdata)
    );

endmodule

/* sim.f */
icache_pkg.sv
cache_array.sv
icache_ctrl.sv
icache_refill.sv
icache_top.sv
tb_icache.sv

/* tb_icache.sv */
`timescale 1ns/1ps

module tb_icache;

    localparam int          INDEX_W        = 4;
    localparam int          TAG_LSB        = 2 + INDEX_W;
    localparam int          LINES          = 1 << INDEX_W;
    localparam logic [31:0] MEM_LAT_MAX    = 32'd5;
    localparam int          WAIT_LIMIT     = 200;
    localparam int          RANDOM_FETCHES = 300;

    logic        clk           = 1'b0;
    logic        rst           = 1'b1;
    logic        cpu_req_valid = 1'b0;
    logic [31:0] cpu_req_addr  = 32'h0;
    logic        cpu_req_ready;
    logic        cpu_resp_valid;
    logic [31:0] cpu_resp_data;
    logic        flush         = 1'b0;
    logic        mem_req_valid;
    logic [31:0] mem_req_addr;
    logic        mem_req_ready = 1'b0;
    logic [31:0] mem_rdata     = 32'h0;

    // reference tag table, indexed like the cache
    logic              ref_valid [LINES];
    logic [31:TAG_LSB] ref_tag   [LINES];

    logic [31:0] exp_data_q  [$];
    int          exp_count_q [$];
    int          exp_mem_count = 0;
    int          mem_count     = 0;
    logic [31:0] cur_addr      = 32'h0;
    logic        mem_busy      = 1'b0;
    logic [31:0] mem_wait      = 32'h0;
    logic [31:0] rng_stim      = 32'h1d38_ac0c;
    logic [31:0] rng_mem       = ~32'h1d38_ac0c;

    icache_top #(
        .INDEX_W (INDEX_W)
    ) dut_i (
        .clk            (clk),
        .rst            (rst),
        .cpu_req_valid  (cpu_req_valid),
        .cpu_req_addr   (cpu_req_addr),
        .cpu_req_ready  (cpu_req_ready),
        .cpu_resp_valid (cpu_resp_valid),
        .cpu_resp_data  (cpu_resp_data),
        .flush          (flush),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_req_ready  (mem_req_ready),
        .mem_rdata      (mem_rdata)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // fixed hash of the word address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] w;
        w = {addr[31:2], 2'b00};
        return (w * 32'h9e37_79b1) ^ {w[15:0], w[31:16]} ^ 32'h5a5a_0f0f;
    endfunction

    function automatic logic predict_miss(input logic [31:0] addr);
        logic [INDEX_W-1:0] idx;
        idx = addr[TAG_LSB-1:2];
        return !(ref_valid[idx] && (ref_tag[idx] == addr[31:TAG_LSB]));
    endfunction

    task automatic record_fill(input logic [31:0] addr);
        logic [INDEX_W-1:0] idx;
        idx = addr[TAG_LSB-1:2];
        ref_valid[idx] = 1'b1;
        ref_tag[idx]   = addr[31:TAG_LSB];
    endtask

    task automatic clear_ref_table();
        for (int i = 0; i < LINES; i++)
        begin
            ref_valid[i] = 1'b0;
            ref_tag[i]   = '0;
        end
    endtask

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp)
        begin
            fail_now($sformatf("[FAIL] t=%0t %s got %08h expected %08h",
                               $time, name, got, exp));
        end
    endtask

    // memory model with random latency
    always @(posedge clk)
    begin
        if (rst)
        begin
            mem_req_ready <= 1'b0;
            mem_busy      <= 1'b0;
        end
        else if (mem_req_ready)
        begin
            // request taken on this edge
            check_val("mem_req_valid", {31'b0, mem_req_valid}, 32'd1);
            check_val("mem_req_addr", mem_req_addr, {cur_addr[31:2], 2'b00});
            mem_count     <= mem_count + 1;
            mem_req_ready <= 1'b0;
            mem_busy      <= 1'b0;
        end
        else if (mem_req_valid && !mem_busy)
        begin
            rng_mem = xorshift(rng_mem);
            mem_busy <= 1'b1;
            mem_wait <= rng_mem % (MEM_LAT_MAX + 32'd1);
        end
        else if (mem_busy)
        begin
            if (mem_wait == 32'd0)
            begin
                mem_req_ready <= 1'b1;
                mem_rdata     <= mem_word(mem_req_addr);
            end
            else
            begin
                mem_wait <= mem_wait - 32'd1;
            end
        end
    end

    // response checker
    always @(posedge clk)
    begin
        if (!rst && cpu_resp_valid)
        begin
            if (exp_data_q.size() == 0)
            begin
                fail_now("a response arrived with no fetch outstanding");
            end
            else
            begin
                check_val("cpu_resp_data", cpu_resp_data, exp_data_q.pop_front());
                check_val("memory request count", mem_count, exp_count_q.pop_front());
            end
        end
    end

    task automatic fetch(input logic [31:0] addr);
        int   waited;
        int   latency;
        logic miss;
        cpu_req_valid <= 1'b1;
        cpu_req_addr  <= addr;
        waited = 0;
        do
        begin
            @(posedge clk);
            waited++;
        end
        while (!cpu_req_ready && waited < WAIT_LIMIT);
        if (!cpu_req_ready)
        begin
            fail_now("the cache never became ready for a fetch");
        end
        cpu_req_valid <= 1'b0;
        miss = predict_miss(addr);
        if (miss)
        begin
            exp_mem_count++;
        end
        record_fill(addr);
        cur_addr = addr;
        exp_data_q.push_back(mem_word(addr));
        exp_count_q.push_back(exp_mem_count);
        latency = 0;
        do
        begin
            @(posedge clk);
            latency++;
        end
        while (!cpu_resp_valid && latency < WAIT_LIMIT);
        if (!cpu_resp_valid)
        begin
            fail_now("no response came back for a fetch");
        end
        if (!miss)
        begin
            check_val("hit latency", latency, 32'd2);
        end
    endtask

    // flush walk is fixed at one line per cycle
    task automatic flush_cache();
        flush <= 1'b1;
        @(posedge clk);
        check_val("cpu_req_ready with flush", {31'b0, cpu_req_ready}, 32'd0);
        flush <= 1'b0;
        for (int i = 0; i < LINES; i++)
        begin
            @(posedge clk);
            check_val("cpu_req_ready during flush", {31'b0, cpu_req_ready}, 32'd0);
        end
        @(posedge clk);
        check_val("cpu_req_ready after flush", {31'b0, cpu_req_ready}, 32'd1);
        clear_ref_table();
    endtask

    initial
    begin
        logic [31:0] addr;
        clear_ref_table();
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // cold miss, then a hit on the same word
        fetch(32'h0000_0106);
        check_val("memory requests", mem_count, 32'd1);
        fetch(32'h0000_0106);
        check_val("memory requests", mem_count, 32'd1);

        // same index, different tags
        fetch(32'h0000_2010);
        check_val("memory requests", mem_count, 32'd2);
        fetch(32'h0000_3010);
        check_val("memory requests", mem_count, 32'd3);
        fetch(32'h0000_2010);
        check_val("memory requests", mem_count, 32'd4);
        fetch(32'h0000_3010);
        check_val("memory requests", mem_count, 32'd5);

        flush_cache();
        fetch(32'h0000_3010);
        check_val("memory requests", mem_count, 32'd6);
        fetch(32'h0000_0106);
        check_val("memory requests", mem_count, 32'd7);

        // 64 words over 16 lines
        for (int n = 0; n < RANDOM_FETCHES; n++)
        begin
            rng_stim = xorshift(rng_stim);
            addr = 32'h0000_1000 + {24'h0, rng_stim[5:0], 2'b00};
            repeat (rng_stim[9:8]) @(posedge clk);
            fetch(addr);
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule
